//--- rtl/scatter_pkg.sv
/*
  Shared widths, register map and state encodings for the scatter client.
  Width constants give the defaults only; the top level passes DATA_WIDTH
  and MAX_SESSIONS down as module parameters.
*/
package scatter_pkg;

  localparam int DATA_WIDTH     = 64;
  localparam int KEEP_WIDTH     = DATA_WIDTH / 8;
  localparam int REG_WIDTH      = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int MAX_SESSIONS   = 8;
  localparam int SESSION_WIDTH  = 16;
  localparam int IP_WIDTH       = 32;
  localparam int PORT_WIDTH     = 16;

  // register word addresses
  typedef enum logic [REG_ADDR_WIDTH-1:0] {
    REG_CTRL      = 5'd0,
    REG_USE_CONN  = 5'd1,
    REG_BASE_IP   = 5'd2,
    REG_BASE_PORT = 5'd3,
    REG_PKG_WORDS = 5'd4,
    REG_PKG_NUM   = 5'd5,
    REG_TX_CMD    = 5'd8,   // read-only from here on
    REG_TX_PKG    = 5'd9,
    REG_STS_GOOD  = 5'd10,
    REG_STS_BAD   = 5'd11,
    REG_BYTES_LO  = 5'd12,
    REG_BYTES_HI  = 5'd13,
    REG_CYCLES    = 5'd14,
    REG_STALL     = 5'd15,
    REG_OPEN_OK   = 5'd16
  } reg_addr_e;

  typedef enum logic [1:0] {OPEN_IDLE, OPEN_REQ, OPEN_WAIT} open_state_e;
  typedef enum logic [1:0] {TX_IDLE, TX_META, TX_DATA, TX_DONE} tx_state_e;

  localparam int OPEN_OK_BIT = 16;  // success flag above the session id
  localparam int TX_ERR_MSB  = 63;
  localparam int TX_ERR_LSB  = 62;  // zero error field means good

endpackage

//--- rtl/scatter_ifs.sv
/*
  Internal bundles of the scatter client.
  scatter_cfg_if carries the run configuration, session_if the session table
  and tx_stats_if the statistics counters. sess_id is a combinational table
  read at sess_idx.
*/
interface scatter_cfg_if import scatter_pkg::*; ();
  logic                  start;
  logic [15:0]           use_conn;
  logic [IP_WIDTH-1:0]   base_ip;
  logic [PORT_WIDTH-1:0] base_port;
  logic [15:0]           pkg_words;
  logic [REG_WIDTH-1:0]  pkg_num;
  logic                  done;

  modport ctrl   (output start, use_conn, base_ip, base_port, pkg_words, pkg_num, input done);
  modport opener (input start, use_conn, base_ip, base_port);
  modport engine (input pkg_words, pkg_num, output done);
endinterface

interface session_if import scatter_pkg::*; #(
  parameter int MAX_SESSIONS = scatter_pkg::MAX_SESSIONS
) ();
  logic                              open_done;
  logic [$clog2(MAX_SESSIONS+1)-1:0] sess_count;
  logic [$clog2(MAX_SESSIONS)-1:0]   sess_idx;
  logic [SESSION_WIDTH-1:0]          sess_id;

  modport tbl     (output open_done, sess_count, sess_id, input sess_idx);
  modport user    (input open_done, sess_count, sess_id, output sess_idx);
  modport monitor (input sess_count);
endinterface

interface tx_stats_if import scatter_pkg::*; ();
  logic [REG_WIDTH-1:0] cmd_cnt;
  logic [REG_WIDTH-1:0] pkg_cnt;
  logic [REG_WIDTH-1:0] sts_good;
  logic [REG_WIDTH-1:0] sts_bad;
  logic [47:0]          bytes;
  logic [REG_WIDTH-1:0] cycles;
  logic [REG_WIDTH-1:0] stall_cnt;
  logic [REG_WIDTH-1:0] open_ok;

  modport counter (output cmd_cnt, pkg_cnt, sts_good, sts_bad, bytes, cycles, stall_cnt);
  modport reader  (input cmd_cnt, pkg_cnt, sts_good, sts_bad, bytes, cycles, stall_cnt,
                   output open_ok);
endinterface

//--- rtl/ctrl_regs.sv
/*
  Host register file with kernel style start, idle and done.
  Writes land at the next edge; reads are combinational.
  A start (bit 0 of REG_CTRL) is taken only while idle, other REG_CTRL
  writes are dropped. use_conn is clamped to MAX_SESSIONS toward the opener,
  the register itself reads back what was written.
*/
module ctrl_regs import scatter_pkg::*; #(
  parameter int MAX_SESSIONS = scatter_pkg::MAX_SESSIONS
) (
  input  logic                      ap_clk,
  input  logic                      ap_rst_n,
  input  logic                      reg_wr_en,
  input  logic [REG_ADDR_WIDTH-1:0] reg_wr_addr,
  input  logic [REG_WIDTH-1:0]      reg_wr_data,
  input  logic [REG_ADDR_WIDTH-1:0] reg_rd_addr,
  output logic [REG_WIDTH-1:0]      reg_rd_data,
  output logic                      idle,
  scatter_cfg_if.ctrl               cfg,
  tx_stats_if.reader                stats,
  session_if.monitor                sess
);

  logic [REG_WIDTH-1:0] use_conn_q;
  logic [REG_WIDTH-1:0] base_ip_q;
  logic [REG_WIDTH-1:0] base_port_q;
  logic [REG_WIDTH-1:0] pkg_words_q;
  logic [REG_WIDTH-1:0] pkg_num_q;
  logic                 start_q;
  logic                 idle_q;
  logic                 start_wr;

  assign start_wr = reg_wr_en && reg_wr_addr == REG_CTRL && reg_wr_data[0] && idle;
  assign idle     = idle_q | cfg.done;  // rises together with done

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      use_conn_q  <= '0;
      base_ip_q   <= '0;
      base_port_q <= '0;
      pkg_words_q <= '0;
      pkg_num_q   <= '0;
      start_q     <= 1'b0;
      idle_q      <= 1'b1;
    end else begin
      start_q <= start_wr;  // one-cycle pulse
      if (start_wr) begin
        idle_q <= 1'b0;
      end else if (cfg.done) begin
        idle_q <= 1'b1;
      end
      if (reg_wr_en) begin
        case (reg_addr_e'(reg_wr_addr))
          REG_USE_CONN:  use_conn_q  <= reg_wr_data;
          REG_BASE_IP:   base_ip_q   <= reg_wr_data;
          REG_BASE_PORT: base_port_q <= reg_wr_data;
          REG_PKG_WORDS: pkg_words_q <= reg_wr_data;
          REG_PKG_NUM:   pkg_num_q   <= reg_wr_data;
          default: ;                 // control and read-only words
        endcase
      end
    end
  end

  assign cfg.start     = start_q;
  assign cfg.use_conn  = (use_conn_q > REG_WIDTH'(MAX_SESSIONS)) ? 16'(MAX_SESSIONS)
                                                                 : use_conn_q[15:0];
  assign cfg.base_ip   = base_ip_q;
  assign cfg.base_port = base_port_q[PORT_WIDTH-1:0];
  assign cfg.pkg_words = pkg_words_q[15:0];
  assign cfg.pkg_num   = pkg_num_q;

  assign stats.open_ok = REG_WIDTH'(sess.sess_count);  // sessions that opened

  always_comb begin
    reg_rd_data = '0;
    case (reg_addr_e'(reg_rd_addr))
      REG_CTRL:      reg_rd_data = REG_WIDTH'({idle, cfg.done, cfg.start});
      REG_USE_CONN:  reg_rd_data = use_conn_q;
      REG_BASE_IP:   reg_rd_data = base_ip_q;
      REG_BASE_PORT: reg_rd_data = base_port_q;
      REG_PKG_WORDS: reg_rd_data = pkg_words_q;
      REG_PKG_NUM:   reg_rd_data = pkg_num_q;
      REG_TX_CMD:    reg_rd_data = stats.cmd_cnt;
      REG_TX_PKG:    reg_rd_data = stats.pkg_cnt;
      REG_STS_GOOD:  reg_rd_data = stats.sts_good;
      REG_STS_BAD:   reg_rd_data = stats.sts_bad;
      REG_BYTES_LO:  reg_rd_data = stats.bytes[31:0];
      REG_BYTES_HI:  reg_rd_data = REG_WIDTH'(stats.bytes[47:32]);
      REG_CYCLES:    reg_rd_data = stats.cycles;
      REG_STALL:     reg_rd_data = stats.stall_cnt;
      REG_OPEN_OK:   reg_rd_data = stats.open_ok;
      default:       reg_rd_data = '0;
    endcase
  end

endmodule

//--- rtl/session_opener.sv
/*
  Opens use_conn connections to base_ip+i on base_port and records the
  session id of every successful open, in status arrival order.
  Statuses may come back in any order. use_conn must be 1 or more.
  MAX_SESSIONS must be at least 2.
*/
module session_opener import scatter_pkg::*; #(
  parameter int MAX_SESSIONS = scatter_pkg::MAX_SESSIONS
) (
  input  logic                           ap_clk,
  input  logic                           ap_rst_n,
  input  logic                           open_conn_tready,
  input  logic                           open_status_tvalid,
  input  logic [23:0]                    open_status_tdata,
  output logic                           open_conn_tvalid,
  output logic [PORT_WIDTH+IP_WIDTH-1:0] open_conn_tdata,
  output logic                           open_status_tready,
  scatter_cfg_if.opener                  cfg,
  session_if.tbl                         sess
);

  localparam int IDX_W = $clog2(MAX_SESSIONS);
  localparam int CNT_W = $clog2(MAX_SESSIONS + 1);

  open_state_e              state;
  logic [15:0]              req_cnt;
  logic [15:0]              sts_cnt;
  logic [CNT_W-1:0]         ok_cnt;
  logic                     open_done_q;
  logic                     sts_take;
  logic [SESSION_WIDTH-1:0] sess_tab [MAX_SESSIONS];

  assign open_conn_tvalid   = (state == OPEN_REQ);
  assign open_conn_tdata    = {cfg.base_port, cfg.base_ip + IP_WIDTH'(req_cnt)};
  assign open_status_tready = 1'b1;
  assign sts_take           = open_status_tvalid && state != OPEN_IDLE;

  assign sess.open_done  = open_done_q;
  assign sess.sess_count = ok_cnt;
  assign sess.sess_id    = sess_tab[sess.sess_idx];  // combinational lookup

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      state       <= OPEN_IDLE;
      req_cnt     <= '0;
      sts_cnt     <= '0;
      ok_cnt      <= '0;
      open_done_q <= 1'b0;
    end else begin
      open_done_q <= 1'b0;
      case (state)
        OPEN_IDLE: if (cfg.start) begin
          state   <= OPEN_REQ;
          req_cnt <= '0;
          sts_cnt <= '0;
          ok_cnt  <= '0;
        end
        OPEN_REQ: if (open_conn_tready) begin
          req_cnt <= req_cnt + 1'b1;
          if (req_cnt + 1'b1 == cfg.use_conn) state <= OPEN_WAIT;  // last request out
        end
        OPEN_WAIT: ;
        default: state <= OPEN_IDLE;
      endcase
      if (sts_take) begin
        sts_cnt <= sts_cnt + 1'b1;
        if (open_status_tdata[OPEN_OK_BIT]) ok_cnt <= ok_cnt + 1'b1;
        if (sts_cnt + 1'b1 == cfg.use_conn) begin  // every status is back
          open_done_q <= 1'b1;
          state       <= OPEN_IDLE;
        end
      end
    end
  end

  // append successful sessions, failures leave no entry
  always_ff @(posedge ap_clk) begin
    if (sts_take && open_status_tdata[OPEN_OK_BIT]) begin
      sess_tab[ok_cnt[IDX_W-1:0]] <= open_status_tdata[SESSION_WIDTH-1:0];
    end
  end

endmodule

//--- rtl/tx_engine.sv
/*
  Sends pkg_num packets round robin over the open sessions.
  Each packet is one metadata beat, then pkg_words full data words.
  Word j of packet p carries p in bits 63:32 and j in bits 31:0, so
  DATA_WIDTH must be at least 64. pkg_words must be 1 or more.
*/
module tx_engine import scatter_pkg::*; #(
  parameter int DATA_WIDTH = scatter_pkg::DATA_WIDTH
) (
  input  logic                    ap_clk,
  input  logic                    ap_rst_n,
  input  logic                    tx_meta_tready,
  input  logic                    tx_data_tready,
  output logic                    tx_meta_tvalid,
  output logic [SESSION_WIDTH+15:0] tx_meta_tdata,
  output logic                    tx_data_tvalid,
  output logic [DATA_WIDTH-1:0]   tx_data_tdata,
  output logic [DATA_WIDTH/8-1:0] tx_data_tkeep,
  output logic                    tx_data_tlast,
  scatter_cfg_if.engine           cfg,
  session_if.user                 sess
);

  tx_state_e            state;
  logic [REG_WIDTH-1:0] pkt_cnt;
  logic [15:0]          word_cnt;

  assign tx_meta_tvalid = (state == TX_META);
  assign tx_meta_tdata  = {cfg.pkg_words[12:0], 3'b000, sess.sess_id};  // bytes, session
  assign tx_data_tvalid = (state == TX_DATA);
  assign tx_data_tdata  = DATA_WIDTH'({pkt_cnt, 16'd0, word_cnt});
  assign tx_data_tkeep  = '1;                                           // full words only
  assign tx_data_tlast  = (word_cnt == cfg.pkg_words - 1'b1);
  assign cfg.done       = (state == TX_DONE);

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      state         <= TX_IDLE;
      pkt_cnt       <= '0;
      word_cnt      <= '0;
      sess.sess_idx <= '0;
    end else begin
      case (state)
        TX_IDLE: if (sess.open_done) begin
          pkt_cnt       <= '0;
          word_cnt      <= '0;
          sess.sess_idx <= '0;
          // nothing to send still gives a done pulse
          state <= (cfg.pkg_num == '0 || sess.sess_count == '0) ? TX_DONE : TX_META;
        end
        TX_META: if (tx_meta_tready) state <= TX_DATA;
        TX_DATA: if (tx_data_tready) begin
          word_cnt <= word_cnt + 1'b1;
          if (tx_data_tlast) begin
            word_cnt <= '0;
            pkt_cnt  <= pkt_cnt + 1'b1;
            if (sess.sess_idx + 1'b1 == sess.sess_count) begin  // wrap the session ring
              sess.sess_idx <= '0;
            end else begin
              sess.sess_idx <= sess.sess_idx + 1'b1;
            end
            state <= (pkt_cnt + 1'b1 == cfg.pkg_num) ? TX_DONE : TX_META;
          end
        end
        TX_DONE: state <= TX_IDLE;  // done is this single cycle
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

//--- rtl/tx_stats.sv
/*
  Transmit statistics, cleared by the start pulse.
  Bytes count the set tkeep bits of accepted data beats in 48 bits.
  Other counters are 32 bits and wrap.
*/
module tx_stats import scatter_pkg::*; #(
  parameter int DATA_WIDTH = scatter_pkg::DATA_WIDTH
) (
  input  logic                    ap_clk,
  input  logic                    ap_rst_n,
  input  logic                    start,
  input  logic                    idle,
  input  logic                    tx_meta_tvalid,
  input  logic                    tx_meta_tready,
  input  logic                    tx_data_tvalid,
  input  logic                    tx_data_tready,
  input  logic [DATA_WIDTH/8-1:0] tx_data_tkeep,
  input  logic                    tx_data_tlast,
  input  logic                    tx_status_tvalid,
  input  logic [TX_ERR_MSB:0]     tx_status_tdata,
  tx_stats_if.counter             stats
);

  logic data_fire;

  assign data_fire = tx_data_tvalid && tx_data_tready;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n || start) begin
      stats.cmd_cnt   <= '0;
      stats.pkg_cnt   <= '0;
      stats.sts_good  <= '0;
      stats.sts_bad   <= '0;
      stats.bytes     <= '0;
      stats.cycles    <= '0;
      stats.stall_cnt <= '0;
    end else begin
      if (tx_meta_tvalid && tx_meta_tready) stats.cmd_cnt <= stats.cmd_cnt + 1'b1;
      if (data_fire && tx_data_tlast) stats.pkg_cnt <= stats.pkg_cnt + 1'b1;
      if (data_fire) stats.bytes <= stats.bytes + 48'($countones(tx_data_tkeep));
      if (tx_status_tvalid) begin  // status is always accepted
        if (tx_status_tdata[TX_ERR_MSB:TX_ERR_LSB] == '0) begin
          stats.sts_good <= stats.sts_good + 1'b1;
        end else begin
          stats.sts_bad <= stats.sts_bad + 1'b1;
        end
      end
      if (!idle) stats.cycles <= stats.cycles + 1'b1;  // run length
      if (tx_data_tvalid && !tx_data_tready) stats.stall_cnt <= stats.stall_cnt + 1'b1;
    end
  end

endmodule

//--- rtl/scatter_top.sv
/*
  TCP scatter benchmark client top level.
  The host uses a plain register write strobe and a combinational read port.
  All stack streams are valid/ready; open and tx status are always accepted.
*/
module scatter_top import scatter_pkg::*; #(
  parameter int DATA_WIDTH   = scatter_pkg::DATA_WIDTH,
  parameter int MAX_SESSIONS = scatter_pkg::MAX_SESSIONS
) (
  input  logic                           ap_clk,
  input  logic                           ap_rst_n,
  input  logic                           reg_wr_en,
  input  logic [REG_ADDR_WIDTH-1:0]      reg_wr_addr,
  input  logic [REG_WIDTH-1:0]           reg_wr_data,
  input  logic [REG_ADDR_WIDTH-1:0]      reg_rd_addr,
  output logic [REG_WIDTH-1:0]           reg_rd_data,
  output logic                           idle,
  output logic                           done,
  output logic                           open_conn_tvalid,
  input  logic                           open_conn_tready,
  output logic [PORT_WIDTH+IP_WIDTH-1:0] open_conn_tdata,
  input  logic                           open_status_tvalid,
  output logic                           open_status_tready,
  input  logic [23:0]                    open_status_tdata,
  output logic                           tx_meta_tvalid,
  input  logic                           tx_meta_tready,
  output logic [SESSION_WIDTH+15:0]      tx_meta_tdata,
  output logic                           tx_data_tvalid,
  input  logic                           tx_data_tready,
  output logic [DATA_WIDTH-1:0]          tx_data_tdata,
  output logic [DATA_WIDTH/8-1:0]        tx_data_tkeep,
  output logic                           tx_data_tlast,
  input  logic                           tx_status_tvalid,
  output logic                           tx_status_tready,
  input  logic [TX_ERR_MSB:0]            tx_status_tdata
);

  scatter_cfg_if                               cfg_if ();
  session_if #(.MAX_SESSIONS(MAX_SESSIONS))    sess_if ();
  tx_stats_if                                  stats_if ();

  assign done             = cfg_if.done;
  assign tx_status_tready = 1'b1;

  ctrl_regs #(.MAX_SESSIONS(MAX_SESSIONS)) ctrl_regs_inst (
    .ap_clk, .ap_rst_n,
    .reg_wr_en, .reg_wr_addr, .reg_wr_data,
    .reg_rd_addr, .reg_rd_data, .idle,
    .cfg   (cfg_if.ctrl),
    .stats (stats_if.reader),
    .sess  (sess_if.monitor)
  );

  session_opener #(.MAX_SESSIONS(MAX_SESSIONS)) session_opener_inst (
    .ap_clk, .ap_rst_n,
    .open_conn_tready, .open_status_tvalid, .open_status_tdata,
    .open_conn_tvalid, .open_conn_tdata, .open_status_tready,
    .cfg  (cfg_if.opener),
    .sess (sess_if.tbl)
  );

  tx_engine #(.DATA_WIDTH(DATA_WIDTH)) tx_engine_inst (
    .ap_clk, .ap_rst_n,
    .tx_meta_tready, .tx_data_tready,
    .tx_meta_tvalid, .tx_meta_tdata,
    .tx_data_tvalid, .tx_data_tdata, .tx_data_tkeep, .tx_data_tlast,
    .cfg  (cfg_if.engine),
    .sess (sess_if.user)
  );

  tx_stats #(.DATA_WIDTH(DATA_WIDTH)) tx_stats_inst (
    .ap_clk, .ap_rst_n,
    .start (cfg_if.start),  // clears the counters
    .idle,
    .tx_meta_tvalid, .tx_meta_tready,
    .tx_data_tvalid, .tx_data_tready, .tx_data_tkeep, .tx_data_tlast,
    .tx_status_tvalid, .tx_status_tdata,
    .stats (stats_if.counter)
  );

endmodule

//--- testbench/tb_scatter.sv
/*
  Testbench for scatter_top. Runs come from testbench/scatter_tests.txt,
  eight hex words per run. Models the stack side of the open and tx streams
  with random ready, checks every beat and the statistics registers.
  Stops at the first mismatch.
*/
module tb_scatter import scatter_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_TESTS = 16;

  logic        ap_clk;
  logic        ap_rst_n;
  logic        reg_wr_en;
  logic [4:0]  reg_wr_addr, reg_rd_addr;
  logic [31:0] reg_wr_data, reg_rd_data;
  logic        idle, done;
  logic        open_conn_tvalid, open_conn_tready, open_status_tvalid, open_status_tready;
  logic [47:0] open_conn_tdata;
  logic [23:0] open_status_tdata;
  logic        tx_meta_tvalid, tx_meta_tready, tx_data_tvalid, tx_data_tready, tx_data_tlast;
  logic [31:0] tx_meta_tdata;
  logic [63:0] tx_data_tdata, tx_status_tdata;
  logic [7:0]  tx_data_tkeep;
  logic        tx_status_tvalid, tx_status_tready;

  logic [31:0] tests [MAX_TESTS*8];
  integer      seed;
  int          limit_cycles;
  logic [31:0] use_conn, base_ip, base_port, pkg_words, pkg_num, fail_mask, err_mask, ready_pct;
  int          req_seen, sts_driven, exp_pkts, meta_seen, word_seen, pkt_seen;
  int          tx_sts_sent, stall_seen, done_seen;
  logic        idle_last;   // idle as seen one cycle earlier
  logic [15:0] exp_sess [$];  // successful ids in status arrival order

  scatter_top #(.DATA_WIDTH(64), .MAX_SESSIONS(8)) scatter_top_inst (.*);

  initial begin
    ap_clk = 1'b0;
    forever #10 ap_clk = ~ap_clk;
  end

  function automatic bit draw_ready();
    return ($unsigned($random(seed)) % 100) < ready_pct;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] want);
    assert (got === want) else begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, want);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
    @(posedge ap_clk);
    #1;
    reg_wr_en   = 1'b1;
    reg_wr_addr = addr;
    reg_wr_data = data;
    @(posedge ap_clk);
    #1 reg_wr_en = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
    @(posedge ap_clk);
    #1 reg_rd_addr = addr;
    @(negedge ap_clk);  // read port is combinational
    data = reg_rd_data;
  endtask

  task automatic expect_reg(input reg_addr_e addr, input logic [31:0] want);
    logic [31:0] rd;
    read_reg(addr, rd);
    check_eq(addr.name(), rd, want);
  endtask

  // stack side, driven just after the edge
  always @(posedge ap_clk) begin
    int idx;
    #1;
    open_conn_tready = draw_ready();
    tx_meta_tready   = draw_ready();
    tx_data_tready   = draw_ready();
    open_status_tvalid = 1'b0;
    // statuses return last request first, once every request is out
    if (req_seen == use_conn && sts_driven < use_conn && draw_ready()) begin
      idx = use_conn - 1 - sts_driven;
      open_status_tdata  = {7'd0, !fail_mask[idx], 16'(100 + idx)};
      open_status_tvalid = 1'b1;
      if (!fail_mask[idx]) exp_sess.push_back(16'(100 + idx));
      sts_driven++;
    end
    tx_status_tvalid = 1'b0;
    if (tx_sts_sent < pkt_seen) begin  // one status per sent packet
      tx_status_tdata  = {(tx_sts_sent < 32 && err_mask[tx_sts_sent]) ? 2'b01 : 2'b00,
                          30'd0, 32'(tx_sts_sent)};
      tx_status_tvalid = 1'b1;
      tx_sts_sent++;
    end
  end

  // beats are sampled mid cycle, they transfer at the next edge
  always @(negedge ap_clk) begin
    if (ap_rst_n) begin
      if (open_conn_tvalid && open_conn_tready) begin
        assert (req_seen < use_conn) else fail_run("open request beyond use_conn");
        check_eq("open_conn_tdata", open_conn_tdata, {base_port[15:0], base_ip + req_seen});
        req_seen++;
      end
      if (open_status_tvalid) check_eq("open_status_tready", open_status_tready, 1'b1);
      if (tx_status_tvalid) check_eq("tx_status_tready", tx_status_tready, 1'b1);
      if (tx_meta_tvalid && tx_meta_tready) begin
        assert (meta_seen < exp_pkts && word_seen == 0)
          else fail_run("tx metadata beat that no packet needs");
        check_eq("tx_meta_tdata", tx_meta_tdata,
                 {16'(pkg_words * 8), exp_sess[meta_seen % exp_sess.size()]});
        meta_seen++;
      end
      if (tx_data_tvalid && !tx_data_tready) stall_seen++;
      if (tx_data_tvalid && tx_data_tready) begin
        assert (meta_seen == pkt_seen + 1) else fail_run("tx data beat without metadata");
        check_eq("tx_data_tdata", tx_data_tdata, {32'(pkt_seen), 32'(word_seen)});
        check_eq("tx_data_tkeep", tx_data_tkeep, 8'hff);
        check_eq("tx_data_tlast", tx_data_tlast, word_seen == pkg_words - 1);
        word_seen++;
        if (word_seen == pkg_words) begin
          word_seen = 0;
          pkt_seen++;
        end
      end
      if (done) begin
        check_eq("idle", idle, 1'b1);  // rises with done
        check_eq("idle before done", idle_last, 1'b0);
        done_seen++;
      end
    end
    idle_last = idle;
  end

  task automatic run_test(input int t);
    reg_addr_e   wr_addr [5];
    logic [31:0] wr_val [5];
    logic [31:0] rd;
    int          n_ok;
    int          good;
    {use_conn, base_ip, base_port, pkg_words} = {tests[t*8], tests[t*8+1],
                                                 tests[t*8+2], tests[t*8+3]};
    {pkg_num, fail_mask, err_mask, ready_pct} = {tests[t*8+4], tests[t*8+5],
                                                 tests[t*8+6], tests[t*8+7]};
    n_ok = 0;
    for (int i = 0; i < use_conn; i++) if (!fail_mask[i]) n_ok++;
    exp_pkts = (n_ok == 0) ? 0 : pkg_num;
    good = 0;
    for (int k = 0; k < exp_pkts; k++) if (!(k < 32 && err_mask[k])) good++;
    {req_seen, sts_driven, meta_seen, word_seen, pkt_seen} = '0;
    {tx_sts_sent, stall_seen, done_seen} = '0;
    exp_sess.delete();
    wr_addr = '{REG_USE_CONN, REG_BASE_IP, REG_BASE_PORT, REG_PKG_WORDS, REG_PKG_NUM};
    wr_val  = '{use_conn, base_ip, base_port, pkg_words, pkg_num};
    for (int i = 0; i < 5; i++) write_reg(wr_addr[i], wr_val[i]);
    for (int i = 0; i < 5; i++) expect_reg(wr_addr[i], wr_val[i]);
    read_reg(REG_CTRL, rd);
    check_eq("REG_CTRL idle bit", rd[2], 1'b1);
    write_reg(REG_CTRL, 32'd1);
    expect_reg(REG_TX_CMD, 32'd0);    // cleared by start
    expect_reg(REG_BYTES_LO, 32'd0);
    wait (done_seen != 0 && tx_sts_sent == exp_pkts);
    @(posedge ap_clk);                // last status counted here
    read_reg(REG_CTRL, rd);
    check_eq("REG_CTRL idle bit", rd[2], 1'b1);
    expect_reg(REG_TX_CMD, exp_pkts);
    expect_reg(REG_TX_PKG, exp_pkts);
    expect_reg(REG_BYTES_LO, exp_pkts * pkg_words * 8);
    expect_reg(REG_BYTES_HI, 32'd0);
    expect_reg(REG_STS_GOOD, good);
    expect_reg(REG_STS_BAD, exp_pkts - good);
    expect_reg(REG_STALL, stall_seen);
    expect_reg(REG_OPEN_OK, n_ok);
    check_eq("done pulses", done_seen, 1);
    check_eq("open requests", req_seen, use_conn);
    check_eq("tx metadata beats", meta_seen, exp_pkts);
    check_eq("tx packets", pkt_seen, exp_pkts);
  endtask

  initial begin
    int n_tests;
    seed         = 32'h91d9_34b3;
    limit_cycles = 0;
    ap_rst_n     = 1'b0;
    idle_last    = 1'b1;
    {reg_wr_en, reg_wr_addr, reg_wr_data, reg_rd_addr} = '0;
    {open_conn_tready, open_status_tvalid, open_status_tdata} = '0;
    {tx_meta_tready, tx_data_tready, tx_status_tvalid, tx_status_tdata} = '0;
    {use_conn, base_ip, base_port, pkg_words, pkg_num, fail_mask, err_mask} = '0;
    ready_pct = 32'd100;
    {req_seen, sts_driven, exp_pkts, meta_seen, word_seen, pkt_seen} = '0;
    {tx_sts_sent, stall_seen, done_seen} = '0;
    foreach (tests[i]) tests[i] = ~32'(i);  // unwritten words hold the inverted index
    $readmemh("testbench/scatter_tests.txt", tests);
    n_tests = 0;
    while (n_tests < MAX_TESTS && tests[n_tests*8] != ~32'(n_tests*8)) begin
      limit_cycles += 200 + tests[n_tests*8+4] * (tests[n_tests*8+3] + 1) * 4;
      n_tests++;
    end
    assert (n_tests > 0) else fail_run("no runs found in testbench/scatter_tests.txt");
    repeat (10) @(posedge ap_clk);
    #1 ap_rst_n = 1'b1;
    @(negedge ap_clk);
    check_eq("idle", idle, 1'b1);
    check_eq("done", done, 1'b0);
    for (int t = 0; t < n_tests; t++) run_test(t);
    $display("TB PASSED");
    $finish;
  end

  // bound on the whole run, scaled by the test list
  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge ap_clk);
    $display("watchdog expired, runs did not finish within %0d cycles", limit_cycles);
    $display("TB FAILED");
    $fatal(1);
  end

endmodule

//--- testbench/scatter_tests.txt
// use_conn base_ip base_port pkg_words pkg_num open_fail_mask tx_err_mask ready_pct
// all hex; open_fail_mask bit i fails request i, tx_err_mask bit k marks status k bad
4 c0a80001 1388 4 a 0 0 64
3 0a000010 2710 2 7 2 5 32
8 fffffffc 1f90 3 c 81 a3 46
2 0a010101 50 1 0 0 0 64
3 0a020202 51 2 5 7 0 50
1 c0a80a0a 1f40 1 9 0 1ff 1e
5 ac100001 22b8 6 8 12 f0 3c
8 0a000001 1388 1 14 0 0 5a

//--- flist.f
rtl/scatter_pkg.sv
rtl/scatter_ifs.sv
rtl/ctrl_regs.sv
rtl/session_opener.sv
rtl/tx_engine.sv
rtl/tx_stats.sv
rtl/scatter_top.sv
testbench/tb_scatter.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the scatter testbench with Verilator and runs it from the project root.
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module tb_scatter -Mdir obj_dir

./obj_dir/Vtb_scatter 2>&1 | tee "$LOG"

if grep -q "TB PASSED" "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG"
  exit 1
fi
